/* Bender.yml */
package:
  name: load_streamer

sources:
  - design/mem_port_pkg.sv
  - design/streamer_pkg.sv
  - design/stream_fifo.sv
  - design/source_addressgen.sv
  - design/load_issuer.sv
  - design/stream_realign.sv
  - design/load_streamer.sv
  - target: test
    files:
      - verification/tb_mem_model.sv
      - verification/tb_load_streamer.sv

/* compile.f */
design/mem_port_pkg.sv
design/streamer_pkg.sv
design/stream_fifo.sv
design/source_addressgen.sv
design/load_issuer.sv
design/stream_realign.sv
design/load_streamer.sv
verification/tb_mem_model.sv
verification/tb_load_streamer.sv

/* design/load_issuer.sv */
// load request issuer and job FSM
`timescale 1ns/1ps

module load_issuer #(
  parameter int unsigned OFFS_DEPTH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          enable_i,
  input  logic                          req_start_i,
  input  logic [31:0]                   addr_i,
  input  logic                          addr_valid_i,
  output logic                          addr_ready_o,
  input  logic                          addrgen_done_i,
  input  logic                          delivered_all_i,
  input  logic                          addr_fifo_empty_i,
  output mem_port_pkg::mem_req_t        mem_req_o,
  input  logic                          gnt_i,
  input  logic                          stream_ready_i,
  output logic [1:0]                    offs_o,
  input  logic                          offs_pop_i,
  output logic                          addrgen_start_o,
  output logic                          gen_clear_o,
  output streamer_pkg::streamer_flags_t flags_o
);

  streamer_pkg::streamer_state_t state_q;
  streamer_pkg::streamer_state_t state_d;

  logic req;
  logic grant;
  logic done;
  logic offs_push_ready;  // room for one more load in flight
  logic offs_empty;

  // request only when the word can be consumed
  assign req = enable_i & (state_q != streamer_pkg::IDLE) & addr_valid_i
             & stream_ready_i & offs_push_ready;
  assign grant        = req & gnt_i;
  assign addr_ready_o = grant;  // pop address on accept

  assign mem_req_o.req     = req;
  assign mem_req_o.addr    = {addr_i[mem_port_pkg::MEM_AW-1:2], 2'b00};  // word aligned
  assign mem_req_o.r_ready = stream_ready_i;

  // byte offsets of loads in flight
  stream_fifo #(
    .payload_t ( logic [1:0] ),
    .DEPTH     ( OFFS_DEPTH  )
  ) i_offs_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_data_i  ( addr_i[1:0]     ),
    .push_valid_i ( grant           ),
    .push_ready_o ( offs_push_ready ),
    .pop_data_o   ( offs_o          ),
    .pop_valid_o  (                 ),
    .pop_ready_i  ( offs_pop_i      ),
    .empty_o      ( offs_empty      )
  );

  always_comb begin
    state_d = state_q;
    done    = 1'b0;
    unique case (state_q)
      streamer_pkg::IDLE: begin
        if (req_start_i) state_d = streamer_pkg::WORKING;
      end
      streamer_pkg::WORKING: begin
        if (addrgen_done_i) state_d = streamer_pkg::DRAIN;  // all addresses out
      end
      streamer_pkg::DRAIN: begin
        if (addr_fifo_empty_i && offs_empty && delivered_all_i) begin
          done    = enable_i;
          state_d = streamer_pkg::IDLE;
        end
      end
      default: state_d = streamer_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= streamer_pkg::IDLE;
    end else if (clear_i) begin
      state_q <= streamer_pkg::IDLE;
    end else if (enable_i) begin
      state_q <= state_d;
    end
  end

  assign addrgen_start_o = enable_i & req_start_i & (state_q == streamer_pkg::IDLE);
  assign gen_clear_o     = clear_i | done;  // generator and word count reset at end

  assign flags_o.ready_start  = (state_q == streamer_pkg::IDLE);
  assign flags_o.done         = done;
  assign flags_o.addrgen_done = addrgen_done_i;

endmodule

/* design/load_streamer.sv */
// memory load streamer top level
`timescale 1ns/1ps

module load_streamer #(
  parameter int unsigned TRANS_CNT  = streamer_pkg::TRANS_W,
  parameter int unsigned OFFS_DEPTH = 4,  // max grant to response latency
  parameter int unsigned MISALIGNED = 1,
  parameter int unsigned ADDR_DEPTH = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  logic                               enable_i,
  input  streamer_pkg::streamer_ctrl_t       ctrl_i,
  output streamer_pkg::streamer_flags_t      flags_o,
  output mem_port_pkg::mem_req_t             mem_req_o,
  input  mem_port_pkg::mem_rsp_t             mem_rsp_i,
  output logic [streamer_pkg::STREAM_DW-1:0] stream_data_o,
  output logic                               stream_valid_o,
  input  logic                               stream_ready_i
);

  logic [31:0] gen_addr;   // generator to address FIFO
  logic        gen_valid;
  logic        gen_ready;
  logic [31:0] fifo_addr;  // address FIFO to issuer
  logic        fifo_valid;
  logic        fifo_ready;
  logic        fifo_empty;
  logic        gen_start;
  logic        gen_clear;
  logic        gen_done;
  logic        delivered_all;
  logic [1:0]  offs;
  logic        offs_pop;

  source_addressgen #(
    .TRANS_CNT ( TRANS_CNT )
  ) i_addressgen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( gen_clear  ),
    .enable_i     ( enable_i   ),
    .start_i      ( gen_start  ),
    .cfg_i        ( ctrl_i.cfg ),
    .addr_o       ( gen_addr   ),
    .addr_valid_o ( gen_valid  ),
    .addr_ready_i ( gen_ready  ),
    .done_o       ( gen_done   )
  );

  stream_fifo #(
    .payload_t ( logic [31:0] ),
    .DEPTH     ( ADDR_DEPTH   )
  ) i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_data_i  ( gen_addr   ),
    .push_valid_i ( gen_valid  ),
    .push_ready_o ( gen_ready  ),
    .pop_data_o   ( fifo_addr  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_ready_i  ( fifo_ready ),
    .empty_o      ( fifo_empty )
  );

  load_issuer #(
    .OFFS_DEPTH ( OFFS_DEPTH )
  ) i_issuer (
    .clk_i             ( clk_i            ),
    .rst_ni            ( rst_ni           ),
    .clear_i           ( clear_i          ),
    .enable_i          ( enable_i         ),
    .req_start_i       ( ctrl_i.req_start ),
    .addr_i            ( fifo_addr        ),
    .addr_valid_i      ( fifo_valid       ),
    .addr_ready_o      ( fifo_ready       ),
    .addrgen_done_i    ( gen_done         ),
    .delivered_all_i   ( delivered_all    ),
    .addr_fifo_empty_i ( fifo_empty       ),
    .mem_req_o         ( mem_req_o        ),
    .gnt_i             ( mem_rsp_i.gnt    ),
    .stream_ready_i    ( stream_ready_i   ),
    .offs_o            ( offs             ),
    .offs_pop_i        ( offs_pop         ),
    .addrgen_start_o   ( gen_start        ),
    .gen_clear_o       ( gen_clear        ),
    .flags_o           ( flags_o          )
  );

  stream_realign #(
    .TRANS_CNT  ( TRANS_CNT  ),
    .MISALIGNED ( MISALIGNED )
  ) i_realign (
    .clk_i           ( clk_i                               ),
    .rst_ni          ( rst_ni                              ),
    .clear_i         ( clear_i                             ),
    .enable_i        ( enable_i                            ),
    .r_valid_i       ( mem_rsp_i.r_valid                   ),
    .r_data_i        ( mem_rsp_i.r_data                    ),
    .offs_i          ( offs                                ),
    .offs_pop_o      ( offs_pop                            ),
    .count_clear_i   ( gen_clear                           ),
    .tot_len_i       ( TRANS_CNT'(ctrl_i.cfg.tot_len)      ),
    .delivered_all_o ( delivered_all                       ),
    .stream_data_o   ( stream_data_o                       ),
    .stream_valid_o  ( stream_valid_o                      ),
    .stream_ready_i  ( stream_ready_i                      )
  );

endmodule

/* design/mem_port_pkg.sv */
// memory port types
package mem_port_pkg;

  // widths
  localparam int unsigned MEM_DW = 64;  // stream word plus 32 bits of headroom
  localparam int unsigned MEM_AW = 32;  // byte address

  // initiator side, driven by the streamer
  typedef struct packed {
    logic              req;      // load request, held until gnt
    logic [MEM_AW-1:0] addr;     // word aligned byte address
    logic              r_ready;  // response taken when high with r_valid
  } mem_req_t;

  // target side, driven by the memory
  typedef struct packed {
    logic              gnt;      // request accepted this cycle
    logic              r_valid;  // one per granted request, in order
    logic [MEM_DW-1:0] r_data;   // held until r_ready
  } mem_rsp_t;

endpackage

/* design/source_addressgen.sv */
// strided address generator
`timescale 1ns/1ps

module source_addressgen #(
  parameter int unsigned TRANS_CNT = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       enable_i,
  input  logic                       start_i,
  input  streamer_pkg::addrgen_cfg_t cfg_i,
  output logic [31:0]                addr_o,
  output logic                       addr_valid_o,
  input  logic                       addr_ready_i,
  output logic                       done_o
);

  streamer_pkg::addrgen_cfg_t cfg_q;  // job config, sampled at start
  logic [31:0]          addr_q;       // current byte address
  logic [31:0]          outer_q;      // start of current inner run
  logic [15:0]          d0_cnt_q;     // position inside the run
  logic [TRANS_CNT-1:0] cnt_q;        // addresses emitted
  logic                 busy_q;
  logic                 done_q;
  logic                 hs;
  logic                 last;
  logic                 wrap;

  assign addr_o       = addr_q;
  assign addr_valid_o = busy_q & enable_i;  // frozen while disabled
  assign done_o       = done_q;

  assign hs   = addr_valid_o & addr_ready_i;
  assign last = (cnt_q + 1'b1 == TRANS_CNT'(cfg_q.tot_len));
  assign wrap = (d0_cnt_q == cfg_q.d0_len - 16'd1);  // end of inner run

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (enable_i) begin
      if (start_i) begin
        busy_q <= (cfg_i.tot_len != '0);
        done_q <= (cfg_i.tot_len == '0);  // empty job is done at once
      end else if (hs && last) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;                   // sticky until clear
      end
    end
  end

  // pattern walk
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q    <= '0;
      addr_q   <= '0;
      outer_q  <= '0;
      d0_cnt_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      addr_q   <= '0;
      outer_q  <= '0;
      d0_cnt_q <= '0;
      cnt_q    <= '0;
    end else if (enable_i) begin
      if (start_i) begin
        cfg_q    <= cfg_i;
        addr_q   <= cfg_i.base_addr;
        outer_q  <= cfg_i.base_addr;
        d0_cnt_q <= '0;
        cnt_q    <= '0;
      end else if (hs) begin
        cnt_q <= cnt_q + 1'b1;
        if (wrap) begin
          d0_cnt_q <= '0;
          outer_q  <= outer_q + cfg_q.d1_stride;  // next run
          addr_q   <= outer_q + cfg_q.d1_stride;
        end else begin
          d0_cnt_q <= d0_cnt_q + 16'd1;
          addr_q   <= addr_q + cfg_q.d0_stride;
        end
      end
    end
  end

endmodule

/* design/stream_fifo.sv */
// synchronous FIFO
`timescale 1ns/1ps

module stream_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  payload_t push_data_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  output payload_t pop_data_o,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // circular buffer
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;          // occupancy
  logic             push;
  logic             pop;

  assign push_ready_o = (cnt_q != CNT_W'(DEPTH));  // room left
  assign pop_valid_o  = (cnt_q != '0);
  assign empty_o      = (cnt_q == '0);
  assign pop_data_o   = mem_q[rd_ptr_q];           // head entry

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end  // both or neither keeps count
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* design/stream_realign.sv */
// response realigner and word counter
`timescale 1ns/1ps

module stream_realign #(
  parameter int unsigned TRANS_CNT  = 16,
  parameter int unsigned MISALIGNED = 1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic                              enable_i,
  input  logic                              r_valid_i,
  input  logic [mem_port_pkg::MEM_DW-1:0]   r_data_i,
  input  logic [1:0]                        offs_i,
  output logic                              offs_pop_o,
  input  logic                              count_clear_i,
  input  logic [TRANS_CNT-1:0]              tot_len_i,
  output logic                              delivered_all_o,
  output logic [streamer_pkg::STREAM_DW-1:0] stream_data_o,
  output logic                              stream_valid_o,
  input  logic                              stream_ready_i
);

  logic [mem_port_pkg::MEM_DW-1:0] hold_q;    // response seen under back-pressure
  logic                            hold_valid_q;
  logic [mem_port_pkg::MEM_DW-1:0] src_data;  // live or held word
  logic [mem_port_pkg::MEM_DW-1:0] shifted;
  logic [TRANS_CNT-1:0]            cnt_q;     // words delivered
  logic                            hs;

  assign src_data       = hold_valid_q ? hold_q : r_data_i;
  assign stream_valid_o = enable_i & (r_valid_i | hold_valid_q);
  assign hs             = stream_valid_o & stream_ready_i;
  assign offs_pop_o     = hs;  // one offset per word

  if (MISALIGNED == 1) begin : gen_misaligned
    assign shifted = src_data >> {offs_i, 3'b000};  // drop offs_i bytes
  end else begin : gen_aligned
    assign shifted = src_data;
  end
  assign stream_data_o = shifted[streamer_pkg::STREAM_DW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (enable_i) begin
      hold_valid_q <= ~hs & (hold_valid_q | r_valid_i);  // keep until taken
    end
  end

  always_ff @(posedge clk_i) begin
    if (enable_i && r_valid_i && !hold_valid_q) begin
      hold_q <= r_data_i;  // first cycle of a response
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || count_clear_i) begin
      cnt_q <= '0;
    end else if (hs) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign delivered_all_o = (cnt_q == tot_len_i);

endmodule

/* design/streamer_pkg.sv */
// streamer job and control types
package streamer_pkg;

  localparam int unsigned STREAM_DW = 32;  // output stream word
  localparam int unsigned TRANS_W   = 16;  // transaction counter width

  // two-level strided pattern
  typedef struct packed {
    logic [31:0] base_addr;  // byte address of first word
    logic [15:0] tot_len;    // stream words in the job
    logic [15:0] d0_len;     // words per inner run
    logic [31:0] d0_stride;  // step inside a run
    logic [31:0] d1_stride;  // step between run starts
  } addrgen_cfg_t;

  // control plane into the streamer
  typedef struct packed {
    logic         req_start;  // one-cycle strobe
    addrgen_cfg_t cfg;
  } streamer_ctrl_t;

  // status back to the controller
  typedef struct packed {
    logic ready_start;   // idle, start accepted
    logic done;          // one-cycle end of job
    logic addrgen_done;  // all addresses produced
  } streamer_flags_t;

  // job FSM
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    WORKING = 2'd1,
    DRAIN   = 2'd2  // waiting for the last words
  } streamer_state_t;

endpackage

/* verification/tb_load_streamer.sv */
// load streamer testbench
`timescale 1ns/1ps

module tb_load_streamer;

  localparam int unsigned JOB_WORDS  = 16 + 3 * 8 + 12 + 40 + 30 + 10;  // all configured words
  localparam int unsigned MAX_CYCLES = 200 * JOB_WORDS + 2000;
  localparam logic [31:0] LFSR_TAPS  = 32'hA300_0000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          clear;
  logic                          enable;
  streamer_pkg::streamer_ctrl_t  ctrl;
  streamer_pkg::streamer_flags_t flags;
  mem_port_pkg::mem_req_t        mem_req;
  mem_port_pkg::mem_rsp_t        mem_rsp;
  logic [31:0]                   stream_data;
  logic                          stream_valid;
  logic                          stream_ready;

  logic [31:0] lfsr_q;
  logic        rand_ready;      // random back-pressure on
  logic        gnt_rnd;
  logic [1:0]  delay_rnd;
  logic [31:0] exp_q [$];       // expected stream words, oldest first
  int unsigned data_errs, proto_errs, flag_errs, cycles;
  int unsigned jobs_started, jobs_done, jobs_cleared, job_words, job_len;
  logic        busy, stall_q, clear_seen, reset_checked;
  logic [31:0] stall_data;

  load_streamer #(
    .OFFS_DEPTH ( 4 ),
    .MISALIGNED ( 1 ),
    .ADDR_DEPTH ( 2 )
  ) dut_i (
    .clk_i, .rst_ni, .clear_i ( clear ), .enable_i ( enable ), .ctrl_i ( ctrl ),
    .flags_o ( flags ), .mem_req_o ( mem_req ), .mem_rsp_i ( mem_rsp ),
    .stream_data_o ( stream_data ), .stream_valid_o ( stream_valid ),
    .stream_ready_i ( stream_ready )
  );

  tb_mem_model mem_i (
    .clk_i, .rst_ni, .clear_i ( clear ), .gnt_rnd_i ( gnt_rnd ),
    .delay_rnd_i ( delay_rnd ), .mem_req_i ( mem_req ), .mem_rsp_o ( mem_rsp )
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] a);
    logic [7:0] b [4];
    for (int i = 0; i < 4; i++) begin
      b[i] = (a + i) & 8'hff ^ ((a + i) >> 8) & 8'hff;  // memory byte rule
    end
    return {b[3], b[2], b[1], b[0]};
  endfunction

  // reference address walk of one job
  task automatic queue_job(input streamer_pkg::addrgen_cfg_t cfg);
    logic [31:0] addr;
    logic [31:0] outer;
    int unsigned pos;
    addr  = cfg.base_addr;
    outer = cfg.base_addr;
    pos   = 0;
    for (int unsigned i = 0; i < cfg.tot_len; i++) begin
      exp_q.push_back(word_at(addr));
      if (pos == cfg.d0_len - 1) begin
        pos   = 0;
        outer = outer + cfg.d1_stride;  // next run
        addr  = outer;
      end else begin
        pos++;
        addr = addr + cfg.d0_stride;
      end
    end
  endtask

  always @(posedge clk_i) begin : random_drive
    logic [4:0] bits;
    for (int k = 0; k < 5; k++) begin
      lfsr_q  = lfsr_step(lfsr_q);  // one step per bit
      bits[k] = lfsr_q[0];
    end
    stream_ready <= rand_ready ? (bits[0] | bits[1]) : 1'b1;
    gnt_rnd      <= bits[2];
    delay_rnd    <= bits[4:3];
  end

  always @(posedge clk_i) begin : monitor
    logic        hs;
    logic [31:0] exp_word;
    hs = stream_valid && stream_ready;
    if (rst_ni) begin
      if (!reset_checked) begin
        assert (flags.ready_start && !flags.done && !flags.addrgen_done) else begin
          flag_errs++;
          $display("Error %0t: flags_o = %b after reset, expected 100", $time, flags);
        end
        reset_checked = 1'b1;
      end
      assert (!(mem_req.req && !stream_ready)) else begin
        proto_errs++;
        $display("Error %0t: mem_req_o.req = 1 while stalled, expected 0", $time);
      end
      if (stall_q) begin
        assert (stream_valid && stream_data == stall_data) else begin
          proto_errs++;
          $display("Error %0t: stream_data_o = %h valid %b under stall, expected %h valid 1",
                   $time, stream_data, stream_valid, stall_data);
        end
      end
      if (clear_seen) begin
        assert (!stream_valid && !mem_req.req && flags.ready_start && !flags.addrgen_done)
        else begin
          proto_errs++;
          $display("stream, request or flags did not return to idle after clear");
        end
      end
      if (busy) begin
        assert (!flags.ready_start) else begin
          flag_errs++;
          $display("Error %0t: flags_o.ready_start = 1 during a job, expected 0", $time);
        end
      end
      if (hs) begin
        job_words++;
        if (exp_q.size() == 0) begin
          data_errs++;
          $display("stream word %h at %0t has no expected word left", stream_data, $time);
        end else begin
          exp_word = exp_q.pop_front();
          assert (stream_data == exp_word) else begin
            data_errs++;
            $display("Error %0t: stream_data_o = %h, expected %h", $time, stream_data, exp_word);
          end
        end
      end
      if (flags.done) begin
        assert (busy && !hs && job_words == job_len && exp_q.size() == 0) else begin
          flag_errs++;
          $display("Error %0t: flags_o.done = 1 after %0d words, expected after %0d (job %b)",
                   $time, job_words, job_len, busy);
        end
        assert (flags.addrgen_done) else begin
          flag_errs++;
          $display("Error %0t: flags_o.addrgen_done = 0 at done, expected 1", $time);
        end
        jobs_done++;
        busy = 1'b0;
      end
      if (ctrl.req_start && flags.ready_start) begin
        queue_job(ctrl.cfg);  // start taken at this edge
        job_len   = ctrl.cfg.tot_len;
        job_words = 0;
        busy      = 1'b1;
        jobs_started++;
      end
      if (clear) begin
        if (busy) jobs_cleared++;
        exp_q.delete();
        busy = 1'b0;
      end
      clear_seen = clear;
      stall_q    = stream_valid && !stream_ready && !clear;
      stall_data = stream_data;
    end
  end

  task automatic start_job(input logic [31:0] base, input logic [15:0] len,
                           input logic [15:0] d0_len, input logic [31:0] d0_stride,
                           input logic [31:0] d1_stride);
    @(posedge clk_i);
    ctrl.cfg.base_addr <= base;
    ctrl.cfg.tot_len   <= len;
    ctrl.cfg.d0_len    <= d0_len;
    ctrl.cfg.d0_stride <= d0_stride;
    ctrl.cfg.d1_stride <= d1_stride;
    ctrl.req_start     <= 1'b1;
    @(posedge clk_i);
    ctrl.req_start <= 1'b0;  // single-cycle strobe
  endtask

  task automatic wait_done();
    @(posedge clk_i);
    while (!flags.done) @(posedge clk_i);
  endtask

  task automatic run_job(input logic [31:0] base, input logic [15:0] len,
                         input logic [15:0] d0_len, input logic [31:0] d0_stride,
                         input logic [31:0] d1_stride);
    start_job(base, len, d0_len, d0_stride, d1_stride);
    wait_done();
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, the job sequence did not finish", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    clk_i = 1'b0;
    rst_ni = 1'b0;
    clear = 1'b0;
    enable = 1'b1;
    ctrl = '0;
    stream_ready = 1'b1;
    gnt_rnd = 1'b0;
    delay_rnd = 2'd0;
    rand_ready = 1'b0;
    lfsr_q = 32'hcfb8;  // fixed seed
    busy = 1'b0;
    stall_q = 1'b0;
    clear_seen = 1'b0;
    reset_checked = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    run_job(32'h0100, 16'd16, 16'd16, 32'd4, 32'd64);  // aligned, contiguous
    for (int off = 1; off < 4; off++) begin
      run_job(32'h0200 * off + off, 16'd8, 16'd8, 32'd4, 32'd64);  // byte offset off
    end
    run_job(32'h0800, 16'd12, 16'd3, 32'd8, 32'd100);  // two-level walk
    rand_ready <= 1'b1;
    start_job(32'h2002, 16'd40, 16'd5, 32'd12, 32'd36);
    repeat (10) @(posedge clk_i);
    ctrl.req_start <= 1'b1;  // busy, must be ignored
    @(posedge clk_i);
    ctrl.req_start <= 1'b0;
    wait_done();
    start_job(32'h3001, 16'd30, 16'd6, 32'd4, 32'd40);
    repeat (20) @(posedge clk_i);
    clear <= 1'b1;  // abort mid-job
    @(posedge clk_i);
    clear <= 1'b0;
    @(posedge clk_i);
    run_job(32'h4003, 16'd10, 16'd2, 32'd4, 32'd20);
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    assert (jobs_done == jobs_started - jobs_cleared) else begin
      flag_errs++;
      $display("done pulsed %0d times for %0d finished jobs",
               jobs_done, jobs_started - jobs_cleared);
    end
    $display("error counts: data %0d, handshake %0d, flags %0d",
             data_errs, proto_errs, flag_errs);
    if (data_errs + proto_errs + flag_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_mem_model.sv */
// memory model for the load port
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   gnt_rnd_i,    // grant for this cycle
  input  logic [1:0]             delay_rnd_i,  // latency pick
  input  mem_port_pkg::mem_req_t mem_req_i,
  output mem_port_pkg::mem_rsp_t mem_rsp_o
);

  logic [31:0]     addr_q [$];         // granted word addresses, oldest first
  longint unsigned due_q [$];          // first cycle each response may show
  longint unsigned cyc;
  logic            r_valid_q = 1'b0;
  logic [63:0]     r_data_q  = '0;

  assign mem_rsp_o = {gnt_rnd_i, r_valid_q, r_data_q};  // gnt, r_valid, r_data

  // byte at a is low byte xor next byte of the address
  function automatic logic [7:0] byte_at(input logic [31:0] a);
    return a[7:0] ^ a[15:8];
  endfunction

  function automatic logic [63:0] word_at(input logic [31:0] w);
    logic [63:0] d;
    for (int i = 0; i < 8; i++) begin
      d[8*i +: 8] = byte_at(w + i);  // little endian
    end
    return d;
  endfunction

  function automatic int unsigned latency(input logic [1:0] pick);
    return (pick == 2'd0) ? 1 : int'(pick);  // 1 to 3 cycles
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q.delete();
      due_q.delete();
      cyc = 0;
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else if (clear_i) begin
      addr_q.delete();  // loads in flight dropped with the streamer
      due_q.delete();
      r_valid_q <= 1'b0;
    end else begin
      cyc++;
      if (r_valid_q && mem_req_i.r_ready) begin
        void'(addr_q.pop_front());  // response taken
        void'(due_q.pop_front());
      end
      if (mem_req_i.req && gnt_rnd_i) begin
        addr_q.push_back(mem_req_i.addr);
        due_q.push_back(cyc + latency(delay_rnd_i) - 1);
      end
      if (addr_q.size() != 0) begin
        r_valid_q <= (due_q[0] <= cyc);  // in order, head waits its turn
        r_data_q  <= word_at(addr_q[0]);
      end else begin
        r_valid_q <= 1'b0;
      end
    end
  end

endmodule
